// ==== hw/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    localparam int wordWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int opcodeWidth  = 7;
    localparam int funct3Width  = 3;
    localparam int numRegs      = 32; // x0 to x31

    typedef logic [wordWidth-1:0]    wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;
    typedef logic [opcodeWidth-1:0]  opcodeT;
    typedef logic [funct3Width-1:0]  funct3T;

    // major opcodes of the supported subset
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAddi   = 7'b0010011; // OP-IMM, only addi used
    localparam opcodeT opRtype  = 7'b0110011;
    localparam opcodeT opLoad   = 7'b0000011; // lw only
    localparam opcodeT opStore  = 7'b0100011; // sw only
    localparam opcodeT opBranch = 7'b1100011; // beq only
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;

    localparam funct3T f3AddSub = 3'b000; // add, sub, addi
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

endpackage

`default_nettype wire

// ==== hw/rvCtrlPkg.sv ====
`default_nettype none

package rvCtrlPkg;

    // value written back to rd
    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10 // link value of jal and jalr
    } resultSelE;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100 // separate code from J
    } immSelE;

    typedef enum logic [1:0] {
        aluAdd    = 2'b00, // address calc
        aluBranch = 2'b01, // compare by subtraction
        aluFunct  = 2'b10, // decode funct3/funct7
        aluLui    = 2'b11
    } aluOpE;

    typedef enum logic [2:0] {
        ctrlAdd   = 3'b000,
        ctrlSub   = 3'b001,
        ctrlAnd   = 3'b010,
        ctrlOr    = 3'b011,
        ctrlSlt   = 3'b101,
        ctrlPassB = 3'b110 // lui
    } aluCtrlE;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      aluSrc;    // 1: immediate on alu b
        immSelE    immSel;
        resultSelE resultSel;
        aluOpE     aluOp;
        logic      pcSrc;     // take a non-sequential pc
        logic      jalrSrc;   // target from alu result
        logic      jumpSrc;   // unconditional jump
    } ctrlT;

endpackage

`default_nettype wire

// ==== hw/mainDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
    input  rvIsaPkg::opcodeT op,
    input  logic             zero,
    output rvCtrlPkg::ctrlT  ctrl
);

    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic branch; // conditional branch opcode

    always_comb begin
        // inactive controls unless a row below turns them on
        ctrl.regWrite  = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.aluSrc    = 1'b0;
        ctrl.immSel    = immI;
        ctrl.resultSel = resAlu;
        ctrl.aluOp     = aluAdd;
        ctrl.jalrSrc   = 1'b0;
        ctrl.jumpSrc   = 1'b0;
        branch         = 1'b0;

        case (op)
            opJal: begin
                ctrl.regWrite  = 1'b1; // rd = pc+4
                ctrl.immSel    = immJ;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSel = resPcPlus4;
                ctrl.jumpSrc   = 1'b1;
            end
            opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSel    = immI; // same layout as addi
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSel = resPcPlus4;
                ctrl.jalrSrc   = 1'b1;
                ctrl.jumpSrc   = 1'b1;
            end
            opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSel    = immI;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSel = resMem;
            end
            opStore: begin
                ctrl.immSel    = immS;
                ctrl.aluSrc    = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSel    = immU;
                ctrl.aluSrc    = 1'b1;
                ctrl.aluOp     = aluLui; // alu passes imm through
            end
            opAddi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSel    = immI;
                ctrl.aluSrc    = 1'b1;
                ctrl.aluOp     = aluFunct;
            end
            opRtype: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluOp     = aluFunct; // rs2 on alu b
            end
            opBranch: begin
                ctrl.immSel    = immB;
                ctrl.aluOp     = aluBranch;
                branch         = 1'b1;
            end
            default: begin
                // unknown opcode, keep everything inactive
            end
        endcase

        ctrl.pcSrc = ctrl.jumpSrc | (branch & zero); // beq taken on zero
    end

endmodule

`default_nettype wire

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  rvIsaPkg::wordT     instr,
    input  logic               zero,
    output rvCtrlPkg::ctrlT    ctrl,
    output rvCtrlPkg::aluCtrlE aluCtrl
);

    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    opcodeT op;
    funct3T funct3;
    logic   funct7b5;

    assign op       = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    mainDecoder uMainDecoder (
        .op   (op),
        .zero (zero),
        .ctrl (ctrl)
    );

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:    aluCtrl = ctrlAdd;
            aluBranch: aluCtrl = ctrlSub;
            aluLui:    aluCtrl = ctrlPassB;
            default: begin // aluFunct
                case (funct3)
                    f3AddSub: aluCtrl = (op[5] & funct7b5) ? ctrlSub : ctrlAdd; // sub only R-type
                    f3Slt:    aluCtrl = ctrlSlt;
                    f3Or:     aluCtrl = ctrlOr;
                    f3And:    aluCtrl = ctrlAnd;
                    default:  aluCtrl = ctrlAdd;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  rvIsaPkg::regAddrT ra1,
    input  rvIsaPkg::regAddrT ra2,
    input  rvIsaPkg::regAddrT wa,
    input  logic              we,
    input  rvIsaPkg::wordT    wd,
    output rvIsaPkg::wordT    rd1,
    output rvIsaPkg::wordT    rd2
);

    import rvIsaPkg::*;

    wordT regs [numRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin // x0 is never written
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rvIsaPkg::wordT     a,
    input  rvIsaPkg::wordT     b,
    input  rvCtrlPkg::aluCtrlE aluCtrl,
    output rvIsaPkg::wordT     result,
    output logic               zero
);

    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b); // signed compare for slt

    always_comb begin
        case (aluCtrl)
            ctrlAdd:   result = a + b;
            ctrlSub:   result = a - b;
            ctrlAnd:   result = a & b;
            ctrlOr:    result = a | b;
            ctrlSlt:   result = {{(wordWidth-1){1'b0}}, lessThan};
            ctrlPassB: result = b; // lui
            default:   result = '0;
        endcase
    end

    assign zero = (result == '0); // beq uses sub result

endmodule

`default_nettype wire

// ==== hw/immExtend.sv ====
`timescale 1ns/1ps
`default_nettype none

module immExtend (
    input  rvIsaPkg::wordT    instr,
    input  rvCtrlPkg::immSelE immSel,
    output rvIsaPkg::wordT    imm
);

    import rvCtrlPkg::*;

    always_comb begin
        case (immSel)
            immI: imm = {{20{instr[31]}}, instr[31:20]};
            immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0}; // byte offset, even
            immJ: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
            immU: imm = {instr[31:12], 12'b0}; // upper 20 bits
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/pcUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           pcSrc,
    input  logic           jalrSrc,
    input  rvIsaPkg::wordT imm,
    input  rvIsaPkg::wordT aluResult,
    output rvIsaPkg::wordT pc,
    output rvIsaPkg::wordT pcPlus4
);

    import rvIsaPkg::*;

    wordT pcTarget;
    wordT pcNext;

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm; // branch and jal

    always_comb begin
        if (!pcSrc) begin
            pcNext = pcPlus4;
        end else if (jalrSrc) begin
            pcNext = {aluResult[31:1], 1'b0}; // jalr clears bit 0
        end else begin
            pcNext = pcTarget;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// ==== hw/riscvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvCore (
    input  logic           clk,
    input  logic           rstN,
    output rvIsaPkg::wordT instrAddr,
    input  rvIsaPkg::wordT instr,
    output rvIsaPkg::wordT dataAddr,
    output rvIsaPkg::wordT writeData,
    output logic           dataWe,
    input  rvIsaPkg::wordT readData
);

    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    ctrlT    ctrl;
    aluCtrlE aluCtrl;
    wordT    pc;
    wordT    pcPlus4;
    wordT    imm;
    wordT    rd1;
    wordT    rd2;
    wordT    srcB;
    wordT    aluResult;
    logic    zero;
    wordT    result; // write-back value

    controlUnit uControlUnit (
        .instr   (instr),
        .zero    (zero),
        .ctrl    (ctrl),
        .aluCtrl (aluCtrl)
    );

    pcUnit uPcUnit (
        .clk       (clk),
        .rstN      (rstN),
        .pcSrc     (ctrl.pcSrc),
        .jalrSrc   (ctrl.jalrSrc),
        .imm       (imm),
        .aluResult (aluResult),
        .pc        (pc),
        .pcPlus4   (pcPlus4)
    );

    regFile uRegFile (
        .clk  (clk),
        .rstN (rstN),
        .ra1  (instr[19:15]), // rs1
        .ra2  (instr[24:20]), // rs2
        .wa   (instr[11:7]),  // rd
        .we   (ctrl.regWrite),
        .wd   (result),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    immExtend uImmExtend (
        .instr  (instr),
        .immSel (ctrl.immSel),
        .imm    (imm)
    );

    alu uAlu (
        .a       (rd1),
        .b       (srcB),
        .aluCtrl (aluCtrl),
        .result  (aluResult),
        .zero    (zero)
    );

    assign srcB   = ctrl.aluSrc ? imm : rd2;
    assign result = (ctrl.resultSel == resMem)     ? readData :
                    (ctrl.resultSel == resPcPlus4) ? pcPlus4  : aluResult;

    assign instrAddr = pc;
    assign dataAddr  = aluResult;
    assign writeData = rd2;
    assign dataWe    = ctrl.memWrite;

endmodule

`default_nettype wire

// ==== verif/riscvCore_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvCoreAssert (
    input logic           clk,
    input logic           rstN,
    input rvIsaPkg::wordT x0Value,
    input rvIsaPkg::wordT instrAddr,
    input logic           dataWe
);

    x0StaysZero: assert property (@(posedge clk) disable iff (!rstN)
        x0Value == '0) // stored x0 even after writes with rd = x0
        else $error("register x0 holds a nonzero value");

    noStoreInReset: assert property (@(posedge clk) !rstN |-> !dataWe)
        else $error("dataWe high while reset is asserted");

    pcAligned: assert property (@(posedge clk) disable iff (!rstN)
        instrAddr[1:0] == 2'b00)
        else $error("instrAddr not word aligned");

endmodule

bind riscvCore riscvCoreAssert uCoreAssert (
    .clk       (clk),
    .rstN      (rstN),
    .x0Value   (uRegFile.regs[0]),
    .instrAddr (instrAddr),
    .dataWe    (dataWe)
);

`default_nettype wire

// ==== verif/riscvCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvCoreTb;

    import rvIsaPkg::*;

    localparam int numTests    = 13;
    localparam int maxCycles   = 20;
    localparam int resetCycles = 5;
    localparam int clkPeriod   = 100;
    localparam int watchdogNs  = numTests * (maxCycles + resetCycles) * clkPeriod + 1000;

    typedef struct packed {
        logic [7:0][31:0] prog;    // word 0 in slot 0
        logic [3:0][31:0] preset;  // data words at 0x10..0x1c
        wordT             expAddr;
        wordT             expData;
        wordT             expPc;   // instrAddr after the store
        logic             checkPc;
    } testRowT;

    logic    clk;
    logic    rstN;
    wordT    instrAddr;
    wordT    instr;
    wordT    dataAddr;
    wordT    writeData;
    logic    dataWe;
    wordT    readData;
    wordT    imem [256];
    wordT    dmem [256];
    wordT    lastStoreAddr;
    wordT    lastStoreData;
    int      storeCount = 0;
    int      curRow;
    int      numRows = 0;
    int      passCount;
    int      failCount;
    integer  seed = 85;
    testRowT testTable [numTests];
    string   testNames [numTests];

    riscvCore DUT (
        .clk       (clk),
        .rstN      (rstN),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .dataWe    (dataWe),
        .readData  (readData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    assign instr    = imem[instrAddr[9:2]]; // combinational fetch
    assign readData = dmem[dataAddr[9:2]];

    // data memory reloaded while reset is held
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= 32'hDA7A0000 | (wordT'(i) << 2);
            end
            for (int i = 0; i < 4; i++) begin
                dmem[4 + i] <= testTable[curRow].preset[i];
            end
        end else if (dataWe) begin
            dmem[dataAddr[9:2]] <= writeData;
            lastStoreAddr       <= dataAddr; // store log
            lastStoreData       <= writeData;
            storeCount          <= storeCount + 1;
        end
    end

    function automatic wordT encI(input logic [11:0] imm, input regAddrT rs1,
                                  input funct3T f3, input regAddrT rd, input opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT encR(input logic f7b5, input regAddrT rs2, input regAddrT rs1,
                                  input funct3T f3, input regAddrT rd);
        return {1'b0, f7b5, 5'b00000, rs2, rs1, f3, rd, opRtype};
    endfunction

    function automatic wordT encS(input logic [11:0] imm, input regAddrT rs2, input regAddrT rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore}; // sw
    endfunction

    function automatic wordT encB(input logic [12:0] imm, input regAddrT rs2, input regAddrT rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic wordT encJ(input logic [20:0] imm, input regAddrT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    task automatic addRow(input string name, input wordT p0, input wordT p1, input wordT p2,
                          input wordT p3, input wordT p4, input wordT p5, input wordT pre0,
                          input wordT expAddr, input wordT expData, input wordT expPc,
                          input logic checkPc);
        testRowT row;
        row.prog      = {32'h0, 32'h0, p5, p4, p3, p2, p1, p0};
        row.preset[0] = pre0;
        for (int i = 1; i < 4; i++) begin
            row.preset[i] = $random(seed);
        end
        row.expAddr            = expAddr;
        row.expData            = expData;
        row.expPc              = expPc;
        row.checkPc            = checkPc;
        testTable[numRows]     = row;
        testNames[numRows]     = name;
        numRows++;
    endtask

    task automatic buildTable();
        logic [11:0] a;
        logic [11:0] b;
        logic [19:0] up;
        wordT        r;
        wordT        sa;
        wordT        sb;
        wordT        ldA;
        wordT        ldB;
        wordT        stX3;
        r    = $random(seed);
        a    = r[11:0];
        up   = r[31:12];
        r    = $random(seed);
        b    = r[11:0];
        sa   = {{20{a[11]}}, a}; // sign extended immediates
        sb   = {{20{b[11]}}, b};
        ldA  = encI(a, 5'd0, f3AddSub, 5'd1, opAddi);
        ldB  = encI(b, 5'd0, f3AddSub, 5'd2, opAddi);
        stX3 = encS(12'h44, 5'd3, 5'd0);
        addRow("addi", ldA, encS(12'h40, 5'd1, 5'd0), '0, '0, '0, '0, $random(seed),
               32'h40, sa, '0, 1'b0);
        addRow("add", ldA, ldB, encR(1'b0, 5'd2, 5'd1, f3AddSub, 5'd3), stX3, '0, '0,
               $random(seed), 32'h44, sa + sb, '0, 1'b0);
        addRow("sub", ldA, ldB, encR(1'b1, 5'd2, 5'd1, f3AddSub, 5'd3), stX3, '0, '0,
               $random(seed), 32'h44, sa - sb, '0, 1'b0);
        addRow("and", ldA, ldB, encR(1'b0, 5'd2, 5'd1, f3And, 5'd3), stX3, '0, '0,
               $random(seed), 32'h44, sa & sb, '0, 1'b0);
        addRow("or", ldA, ldB, encR(1'b0, 5'd2, 5'd1, f3Or, 5'd3), stX3, '0, '0,
               $random(seed), 32'h44, sa | sb, '0, 1'b0);
        addRow("sltNeg", encI(12'hFFB, 5'd0, f3AddSub, 5'd1, opAddi), // x1 = -5
               encI({1'b0, b[10:0]}, 5'd0, f3AddSub, 5'd2, opAddi), // x2 nonnegative
               encR(1'b0, 5'd2, 5'd1, f3Slt, 5'd3), stX3, '0, '0, $random(seed),
               32'h44, 32'd1, '0, 1'b0); // -5 is below any nonnegative value
        addRow("luiAddi", {up, 5'd1, opLui}, encI(a, 5'd1, f3AddSub, 5'd1, opAddi),
               encS(12'h48, 5'd1, 5'd0), '0, '0, '0, $random(seed),
               32'h48, {up, 12'h000} + sa, '0, 1'b0);
        r = $random(seed);
        addRow("lwSw", encI(12'h10, 5'd0, 3'b010, 5'd1, opLoad), encS(12'h50, 5'd1, 5'd0),
               '0, '0, '0, '0, r, 32'h50, r, '0, 1'b0);
        addRow("beqTaken", encI(12'd7, 5'd0, f3AddSub, 5'd1, opAddi),
               encI(12'd7, 5'd0, f3AddSub, 5'd2, opAddi),
               encI(12'h11, 5'd0, f3AddSub, 5'd3, opAddi), encB(13'd8, 5'd2, 5'd1),
               encI(12'h22, 5'd0, f3AddSub, 5'd3, opAddi), encS(12'h54, 5'd3, 5'd0),
               $random(seed), 32'h54, 32'h11, '0, 1'b0);
        addRow("beqNotTaken", encI(12'd7, 5'd0, f3AddSub, 5'd1, opAddi),
               encI(12'd8, 5'd0, f3AddSub, 5'd2, opAddi),
               encI(12'h11, 5'd0, f3AddSub, 5'd3, opAddi), encB(13'd8, 5'd2, 5'd1),
               encI(12'h22, 5'd0, f3AddSub, 5'd3, opAddi), encS(12'h54, 5'd3, 5'd0),
               $random(seed), 32'h54, 32'h22, '0, 1'b0);
        // jal at 4 jumps to 12 with link 8
        addRow("jal", encI(12'd1, 5'd0, f3AddSub, 5'd1, opAddi), encJ(21'd8, 5'd5),
               encI(12'd0, 5'd0, f3AddSub, 5'd5, opAddi), encS(12'h58, 5'd5, 5'd0),
               '0, '0, $random(seed), 32'h58, 32'd8, 32'd16, 1'b1);
        // target 17 with bit 0 cleared lands on the store at 16
        addRow("jalr", encI(12'd17, 5'd0, f3AddSub, 5'd1, opAddi),
               encI(12'd0, 5'd1, 3'b000, 5'd6, opJalr),
               encI(12'd0, 5'd0, f3AddSub, 5'd6, opAddi),
               encI(12'd0, 5'd0, f3AddSub, 5'd6, opAddi), encS(12'h5C, 5'd6, 5'd0), '0,
               $random(seed), 32'h5C, 32'd8, (32'd17 & ~32'd1) + 32'd4, 1'b1);
        addRow("resetClears", encI(12'd0, 5'd0, f3AddSub, 5'd0, opAddi),
               encS(12'h60, 5'd3, 5'd0), '0, '0, '0, '0, $random(seed),
               32'h60, 32'h0, '0, 1'b0); // x3 was written by earlier rows
    endtask

    task automatic loadProgram(input int row);
        for (int i = 0; i < 256; i++) begin
            imem[i] = encI(12'(i), 5'd0, f3AddSub, 5'd0, opAddi); // nop with imm from address
        end
        for (int i = 0; i < 8; i++) begin
            if (testTable[row].prog[i] != '0) begin
                imem[i] = testTable[row].prog[i];
            end
        end
    endtask

    task automatic runTest(input int row);
        int   startCount;
        int   cycles;
        logic ok;
        curRow = row;
        rstN   = 1'b0;
        loadProgram(row);
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN       = 1'b1;
        ok         = 1'b1;
        cycles     = 0;
        startCount = storeCount;
        if (instrAddr != '0) begin
            $display("CHECK FAILED %s first instrAddr expected %h actual %h",
                     testNames[row], 32'h0, instrAddr);
            ok = 1'b0;
        end
        while (storeCount == startCount && cycles < maxCycles) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (storeCount == startCount) begin
            $display("%s: no store seen within 20 cycles", testNames[row]);
            ok = 1'b0;
        end else begin
            if (lastStoreAddr != testTable[row].expAddr) begin
                $display("CHECK FAILED %s store address expected %h actual %h",
                         testNames[row], testTable[row].expAddr, lastStoreAddr);
                ok = 1'b0;
            end
            if (lastStoreData != testTable[row].expData) begin
                $display("CHECK FAILED %s store data expected %h actual %h",
                         testNames[row], testTable[row].expData, lastStoreData);
                ok = 1'b0;
            end
            if (testTable[row].checkPc && instrAddr != testTable[row].expPc) begin
                $display("CHECK FAILED %s instrAddr after store expected %h actual %h",
                         testNames[row], testTable[row].expPc, instrAddr);
                ok = 1'b0;
            end
        end
        if (ok) begin
            passCount++;
            $display("test %s passed", testNames[row]);
        end else begin
            failCount++;
            $display("test %s failed", testNames[row]);
        end
    endtask

    initial begin
        #(watchdogNs);
        $display("watchdog expired before all tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rstN      = 1'b0;
        curRow    = 0;
        passCount = 0;
        failCount = 0;
        buildTable();
        for (int row = 0; row < numTests; row++) begin
            runTest(row);
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/rvIsaPkg.sv
hw/rvCtrlPkg.sv
hw/mainDecoder.sv
hw/controlUnit.sv
hw/regFile.sv
hw/alu.sv
hw/immExtend.sv
hw/pcUnit.sv
hw/riscvCore.sv
verif/riscvCore_assert.sv
verif/riscvCoreTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f tb.f --top-module riscvCoreTb -o riscvSim \
    && ./obj_dir/riscvSim | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
